// File: rtl/soc_settings.svh
// SoC core constants
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_ADR_W 19            // Word address, bits [19:1]
`define SOC_DAT_W 16

// Memory depths, log2 of words
`define SOC_ROM_AW 4            // 16 words, aliased over the 256 byte window
`define SOC_RAM_AW 10

// Decode windows, matched against {tga, adr[19:1]}
// A bit set in the mask takes part in the compare
`define SOC_ROM_BASE  20'h7ff80 // mem 0xfff00 - 0xfffff
`define SOC_ROM_MASK  20'hfff80
`define SOC_GPIO_BASE 20'h87880 // io 0xf100 - 0xf103
`define SOC_GPIO_MASK 20'h87ffe

// Interrupts
`define SOC_NUM_IRQ      8
`define SOC_NMI_VEC      16'h0002
`define SOC_INT_VEC_BASE 16'h0008

// Reset hold after the reset pin or lock returns high
`define SOC_RST_CYCLES 16

// Board outputs
`define SOC_LED_W 12

`endif

// File: rtl/soc_pkg.sv
// Bus and decode types
package soc_pkg;

  `include "soc_settings.svh"

  // Word address, byte address bit 0 is not carried
  typedef logic [`SOC_ADR_W:1] adr_t;

  // Bus data and byte lane selects
  typedef logic [`SOC_DAT_W-1:0]   dat_t;
  typedef logic [`SOC_DAT_W/8-1:0] sel_t;

  // Interrupt number
  typedef logic [$clog2(`SOC_NUM_IRQ)-1:0] iid_t;

  // Master to slave
  typedef struct packed {
    logic tga;   // High for I/O space
    adr_t adr;
    dat_t dat;
    sel_t sel;
    logic we;
    logic cyc;
    logic stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    dat_t dat;
    logic ack;
  } wb_rsp_t;

  // Decoder result, in no particular priority order
  typedef enum logic [1:0] {
    SLV_ROM,
    SLV_RAM,
    SLV_GPIO,
    SLV_DEF
  } slave_e;

endpackage

// File: rtl/reset_debounce.sv
// Reset debounce and stretch
`timescale 1ns/1ps
`include "soc_settings.svh"

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,   // Low while the button is pressed or the clock is unlocked
  output logic rst_o
);

  localparam int CNT_W = $clog2(`SOC_RST_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt_q <= CNT_W'(`SOC_RST_CYCLES);   // Reload and hold
      rst_o <= 1'b1;
    end else begin
      if (cnt_q != '0)
        cnt_q <= cnt_q - 1'b1;
      rst_o <= (cnt_q != '0);
    end
  end

endmodule

// File: rtl/bus_decoder.sv
// Address decoder and default slave
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder (
  input  logic             clk,
  input  logic             rst_i,
  // Master side
  input  soc_pkg::wb_req_t m_req_i,
  output soc_pkg::wb_rsp_t m_rsp_o,
  // Slave side
  output soc_pkg::wb_req_t rom_req_o,
  output soc_pkg::wb_req_t ram_req_o,
  output soc_pkg::wb_req_t gpio_req_o,
  input  soc_pkg::wb_rsp_t rom_rsp_i,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  input  soc_pkg::wb_rsp_t gpio_rsp_i
);

  logic [`SOC_ADR_W:0] win_adr;   // {tga, adr} as in the window tables
  soc_pkg::slave_e     slv;
  logic                bus_en_q;  // Low through reset and its first cycle out
  logic                req_vld;

  function automatic logic win_hit(input logic [`SOC_ADR_W:0] a,
                                   input logic [`SOC_ADR_W:0] base,
                                   input logic [`SOC_ADR_W:0] mask);
    return ((a ^ base) & mask) == '0;
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i)
      bus_en_q <= 1'b0;
    else
      bus_en_q <= 1'b1;
  end

  assign win_adr = {m_req_i.tga, m_req_i.adr};
  assign req_vld = m_req_i.cyc & bus_en_q;

  // Fixed priority ROM, GPIO, RAM, then default
  always_comb begin
    if (win_hit(win_adr, `SOC_ROM_BASE, `SOC_ROM_MASK))
      slv = soc_pkg::SLV_ROM;
    else if (win_hit(win_adr, `SOC_GPIO_BASE, `SOC_GPIO_MASK))
      slv = soc_pkg::SLV_GPIO;
    else if (!m_req_i.tga)
      slv = soc_pkg::SLV_RAM;     // Rest of memory space
    else
      slv = soc_pkg::SLV_DEF;     // Unmapped I/O
  end

  // Request fan-out, only the selected slave sees cyc
  always_comb begin
    rom_req_o      = m_req_i;
    ram_req_o      = m_req_i;
    gpio_req_o     = m_req_i;
    rom_req_o.cyc  = req_vld && (slv == soc_pkg::SLV_ROM);
    ram_req_o.cyc  = req_vld && (slv == soc_pkg::SLV_RAM);
    gpio_req_o.cyc = req_vld && (slv == soc_pkg::SLV_GPIO);
  end

  // Response mux
  always_comb begin
    unique case (slv)
      soc_pkg::SLV_ROM:  m_rsp_o = rom_rsp_i;
      soc_pkg::SLV_RAM:  m_rsp_o = ram_rsp_i;
      soc_pkg::SLV_GPIO: m_rsp_o = gpio_rsp_i;
      soc_pkg::SLV_DEF: begin
        m_rsp_o.dat = '0;
        m_rsp_o.ack = req_vld & m_req_i.stb;   // Same cycle ack
      end
    endcase
  end

endmodule

// File: rtl/boot_rom.sv
// Boot ROM slave
`timescale 1ns/1ps
`include "soc_settings.svh"

module boot_rom (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  soc_pkg::dat_t           mem [0:2**`SOC_ROM_AW-1];
  soc_pkg::dat_t           rdat_q;
  logic                    ack_q;
  logic                    acc;
  logic [`SOC_ROM_AW-1:0]  idx;

  initial begin
    $readmemh("rom.hex", mem);
  end

  assign acc = req_i.cyc & req_i.stb & ~ack_q;   // Writes are acked and dropped
  assign idx = req_i.adr[`SOC_ROM_AW:1];          // Upper window bits alias

  always_ff @(posedge clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= acc;
  end

  always_ff @(posedge clk) begin
    if (acc)
      rdat_q <= mem[idx];
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

// File: rtl/base_ram.sv
// Base RAM slave
`timescale 1ns/1ps
`include "soc_settings.svh"

module base_ram (
  input  logic             clk,
  input  logic             rst_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  soc_pkg::dat_t          mem [0:2**`SOC_RAM_AW-1];
  soc_pkg::dat_t          rdat_q;
  logic                   ack_q;
  logic                   acc;
  logic [`SOC_RAM_AW-1:0] idx;

  assign acc = req_i.cyc & req_i.stb & ~ack_q;
  assign idx = req_i.adr[`SOC_RAM_AW:1];   // Higher address bits alias

  always_ff @(posedge clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= acc;
  end

  // Storage and read port
  always_ff @(posedge clk) begin
    if (acc) begin
      if (req_i.we) begin
        if (req_i.sel[0])
          mem[idx][7:0] <= req_i.dat[7:0];
        if (req_i.sel[1])
          mem[idx][15:8] <= req_i.dat[15:8];
      end
      rdat_q <= mem[idx];   // Old word on a write
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

// File: rtl/gpio_port.sv
// Switch and LED port
`timescale 1ns/1ps
`include "soc_settings.svh"

module gpio_port (
  input  logic                  clk,
  input  logic                  rst_i,
  input  soc_pkg::wb_req_t      req_i,
  output soc_pkg::wb_rsp_t      rsp_o,
  input  logic [7:0]            sw_i,
  output logic [`SOC_LED_W-1:0] leds_o
);

  logic [`SOC_LED_W-1:0] led_q;
  soc_pkg::dat_t         rdat_q;
  logic                  ack_q;
  logic                  acc;
  logic                  led_sel;   // Word 1 at 0xf102

  assign acc     = req_i.cyc & req_i.stb & ~ack_q;
  assign led_sel = req_i.adr[1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      led_q <= '0;
    end else begin
      ack_q <= acc;
      if (acc && req_i.we && led_sel) begin
        if (req_i.sel[0])
          led_q[7:0] <= req_i.dat[7:0];
        if (req_i.sel[1])
          led_q[`SOC_LED_W-1:8] <= req_i.dat[`SOC_LED_W-1:8];
      end
    end
  end

  // Read data, switch word ignores writes
  always_ff @(posedge clk) begin
    if (acc) begin
      if (led_sel)
        rdat_q <= soc_pkg::dat_t'(led_q);
      else
        rdat_q <= soc_pkg::dat_t'(sw_i);
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;
  assign leds_o    = led_q;

endmodule

// File: rtl/int_ctrl.sv
// Priority interrupt controller
`timescale 1ns/1ps
`include "soc_settings.svh"

module int_ctrl (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic [`SOC_NUM_IRQ-1:0] irq_i,
  input  logic                    inta_i,
  output logic                    intr_o,
  output soc_pkg::iid_t           iid_o
);

  logic [`SOC_NUM_IRQ-1:0] irq_q;
  logic [`SOC_NUM_IRQ-1:0] pend_q;
  logic [`SOC_NUM_IRQ-1:0] clr;
  logic                    inta_q;

  // Lowest pending index wins
  always_comb begin
    iid_o = '0;
    for (int i = `SOC_NUM_IRQ - 1; i >= 0; i--) begin
      if (pend_q[i])
        iid_o = soc_pkg::iid_t'(i);
    end
  end

  // Clear on the falling edge of inta, so the vector holds through the ack
  assign clr = (inta_q && !inta_i) ? ({{(`SOC_NUM_IRQ-1){1'b0}}, 1'b1} << iid_o) : '0;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q  <= '0;
      pend_q <= '0;
      inta_q <= 1'b0;
    end else begin
      irq_q  <= irq_i;
      inta_q <= inta_i;
      pend_q <= (pend_q & ~clr) | (irq_i & ~irq_q);   // New edge beats a clear
    end
  end

  assign intr_o = |pend_q;

endmodule

// File: rtl/soc_top.sv
// SoC processor-facing core
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
  input  logic                    clk,
  input  logic                    rst_lck,   // Reset pin and lock, active low
  input  soc_pkg::wb_req_t        bus_i,
  output soc_pkg::wb_rsp_t        bus_o,
  input  logic [7:0]              sw_i,
  output logic [`SOC_LED_W-1:0]   leds_o,
  input  logic [`SOC_NUM_IRQ-1:0] irq_i,
  input  logic                    inta_i,
  output logic                    intr_o,
  input  logic                    nmi_i,
  output logic                    nmi_o,
  input  logic                    nmia_i
);

  logic             rst;
  soc_pkg::wb_rsp_t dec_rsp;     // Bus side of the decoder
  soc_pkg::wb_req_t rom_req, ram_req, gpio_req;
  soc_pkg::wb_rsp_t rom_rsp, ram_rsp, gpio_rsp;
  soc_pkg::iid_t    iid;

  reset_debounce i_rst (.clk(clk), .rst_lck(rst_lck), .rst_o(rst));

  bus_decoder i_dec (
    .clk        (clk),
    .rst_i      (rst),
    .m_req_i    (bus_i),
    .m_rsp_o    (dec_rsp),
    .rom_req_o  (rom_req),
    .ram_req_o  (ram_req),
    .gpio_req_o (gpio_req),
    .rom_rsp_i  (rom_rsp),
    .ram_rsp_i  (ram_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  boot_rom i_rom (.clk(clk), .rst_i(rst), .req_i(rom_req), .rsp_o(rom_rsp));

  base_ram i_ram (.clk(clk), .rst_i(rst), .req_i(ram_req), .rsp_o(ram_rsp));

  gpio_port i_gpio (
    .clk    (clk),
    .rst_i  (rst),
    .req_i  (gpio_req),
    .rsp_o  (gpio_rsp),
    .sw_i   (sw_i),
    .leds_o (leds_o)
  );

  int_ctrl i_pic (
    .clk    (clk),
    .rst_i  (rst),
    .irq_i  (irq_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

  // Acknowledge cycles put the vector on the read data, NMI first
  always_comb begin
    bus_o.ack = dec_rsp.ack;
    if (nmia_i)
      bus_o.dat = `SOC_NMI_VEC;
    else if (inta_i)
      bus_o.dat = `SOC_INT_VEC_BASE + soc_pkg::dat_t'(iid);
    else
      bus_o.dat = dec_rsp.dat;
  end

  assign nmi_o = nmi_i;

endmodule

// File: test/tb_model.svh
// Testbench models and bus tasks
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0]             rom_m [0:2**`SOC_ROM_AW-1];
logic [15:0]             ram_m [0:2**`SOC_RAM_AW-1];
logic [`SOC_LED_W-1:0]   led_m;
logic [`SOC_NUM_IRQ-1:0] pend_m;   // Pending interrupt set
logic [15:0]             lfsr;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v    = {v[30:0], lfsr[0]};
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
  end
  return v;
endfunction

function automatic logic [15:0] lane_merge(input logic [15:0] old_d, input logic [15:0] new_d,
                                           input logic [1:0] sel);
  return {sel[1] ? new_d[15:8] : old_d[15:8], sel[0] ? new_d[7:0] : old_d[7:0]};
endfunction

function automatic soc_pkg::iid_t lowest_pending(input logic [`SOC_NUM_IRQ-1:0] p);
  for (int i = 0; i < `SOC_NUM_IRQ; i++) begin
    if (p[i])
      return soc_pkg::iid_t'(i);
  end
  return '0;
endfunction

// Unmapped I/O acks at once, every other slave a cycle later
function automatic int ack_latency(input logic io, input logic [19:0] badr);
  return (io && badr[19:2] != 18'h03c40) ? 0 : 1;
endfunction

task automatic abort_run(input string why);
  $display("%s", why);
  $display("Test failed");
  $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp)
    abort_run($sformatf("FAIL time %0t ns %s got %h expected %h", $time, name, got, exp));
endtask

// Starts and ends on a falling edge
task automatic bus_cycle(input logic io, input logic wr, input logic [19:0] badr,
                         input logic [15:0] wdat, input logic [1:0] sel,
                         input logic [15:0] exp);
  int n;
  bus_i = '{tga: io, adr: badr[19:1], dat: wdat, sel: sel, we: wr, cyc: 1'b1, stb: 1'b1};
  if (!wr)
    exp_q.push_back(exp);
  n = 0;
  #1;
  while (!bus_o.ack) begin
    if (n == ACK_TIMEOUT)
      abort_run("Timeout, a bus cycle was never acked");
    @(negedge clk);
    #1;
    n++;
  end
  check("ack latency", n, ack_latency(io, badr));
  @(negedge clk);
  bus_i = '0;
endtask

task automatic wait_intr(input logic lvl);
  int n;
  n = 0;
  while (intr_o !== lvl) begin
    if (n == ACK_TIMEOUT)
      abort_run("Timeout, intr_o never reached the expected level");
    @(negedge clk);
    n++;
  end
endtask

`endif

// File: test/tb_soc.sv
// SoC core testbench
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc;

  localparam int CLK_HALF    = 2;    // 4 ns period
  localparam int ACK_TIMEOUT = 16;
  localparam int RAM_WORDS   = 24;   // Random RAM locations
  localparam int NIRQ        = `SOC_NUM_IRQ;

  logic                    clk;
  logic                    rst_lck;
  soc_pkg::wb_req_t        bus_i;
  soc_pkg::wb_rsp_t        bus_o;
  logic [7:0]              sw_i;
  logic [`SOC_LED_W-1:0]   leds_o;
  logic [`SOC_NUM_IRQ-1:0] irq_i;
  logic                    inta_i, intr_o;
  logic                    nmi_i, nmi_o, nmia_i;
  logic [15:0]             exp_q [$];   // Expected read data in issue order

  `include "tb_model.svh"

  soc_top i_dut (
    .clk(clk), .rst_lck(rst_lck),
    .bus_i(bus_i), .bus_o(bus_o),
    .sw_i(sw_i), .leds_o(leds_o),
    .irq_i(irq_i), .inta_i(inta_i), .intr_o(intr_o),
    .nmi_i(nmi_i), .nmi_o(nmi_o), .nmia_i(nmia_i)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Every acked read against the queued model value
  always @(posedge clk) begin
    if (bus_i.cyc && bus_i.stb && !bus_i.we && bus_o.ack) begin
      if (exp_q.size() == 0)
        abort_run("A read was acked with no expected value queued");
      else
        check("bus_o.dat", bus_o.dat, exp_q.pop_front());
    end
  end

  initial begin
    logic [19:0] badr;
    logic [19:0] ram_adr [RAM_WORDS];
    logic [15:0] wdat;
    logic [1:0]  sel;

    rst_lck = 1'b0;
    bus_i   = '0;
    sw_i    = '0;
    irq_i   = '0;
    inta_i  = 1'b0;
    nmi_i   = 1'b0;
    nmia_i  = 1'b0;
    lfsr    = 16'd92;
    led_m   = '0;
    $readmemh("rom.hex", rom_m);

    repeat (2) @(negedge clk);
    rst_lck = 1'b1;
    repeat (`SOC_RST_CYCLES + 3) @(negedge clk);   // Debounce hold plus decoder enable
    check("leds_o", leds_o, '0);
    check("intr_o", intr_o, 1'b0);
    check("nmi_o", nmi_o, 1'b0);

    // RAM with a full word first so no lane stays undefined
    for (int i = 0; i < RAM_WORDS; i++) begin
      badr = 20'(rand_bits(19)) << 1;
      badr[19] = 1'b0;   // Below the ROM window
      ram_adr[i] = badr;
      wdat = 16'(rand_bits(16));
      bus_cycle(1'b0, 1'b1, badr, wdat, 2'b11, '0);
      ram_m[badr[`SOC_RAM_AW:1]] = wdat;
      wdat = 16'(rand_bits(16));
      sel  = 2'(rand_bits(2));
      bus_cycle(1'b0, 1'b1, badr, wdat, sel, '0);
      ram_m[badr[`SOC_RAM_AW:1]] = lane_merge(ram_m[badr[`SOC_RAM_AW:1]], wdat, sel);
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      badr = ram_adr[i];
      bus_cycle(1'b0, 1'b0, badr, '0, 2'b11, ram_m[badr[`SOC_RAM_AW:1]]);
      badr = {1'b0, 8'(rand_bits(8)), ram_adr[i][10:0]};   // Alias above the index
      bus_cycle(1'b0, 1'b0, badr, '0, 2'b11, ram_m[badr[`SOC_RAM_AW:1]]);
    end

    // ROM reads across the window and a write that must not stick
    for (int i = 0; i < 24; i++) begin
      badr = {12'hfff, 7'(rand_bits(7)), 1'b0};
      bus_cycle(1'b0, 1'b0, badr, '0, 2'b11, rom_m[badr[`SOC_ROM_AW:1]]);
    end
    bus_cycle(1'b0, 1'b1, 20'hfff0a, 16'h5a5a, 2'b11, '0);
    bus_cycle(1'b0, 1'b0, 20'hfff0a, '0, 2'b11, rom_m[5]);

    sw_i = 8'(rand_bits(8));
    bus_cycle(1'b1, 1'b0, 20'h0f100, '0, 2'b11, {8'h00, sw_i});
    bus_cycle(1'b1, 1'b1, 20'h0f100, 16'hffff, 2'b11, '0);   // Switch word ignores it
    bus_cycle(1'b1, 1'b0, 20'h0f100, '0, 2'b11, {8'h00, sw_i});
    for (int i = 0; i < 6; i++) begin
      wdat = 16'(rand_bits(16));
      sel  = 2'(rand_bits(2));
      bus_cycle(1'b1, 1'b1, 20'h0f102, wdat, sel, '0);
      led_m = `SOC_LED_W'(lane_merge({4'h0, led_m}, wdat, sel));
      check("leds_o", leds_o, led_m);
      bus_cycle(1'b1, 1'b0, 20'h0f102, '0, 2'b11, {4'h0, led_m});
    end
    bus_cycle(1'b1, 1'b0, 20'h003f8, '0, 2'b11, 16'h0000);   // Unmapped I/O

    nmi_i = 1'b1;
    #1;
    check("nmi_o", nmi_o, 1'b1);
    @(negedge clk);
    nmi_i  = 1'b0;
    irq_i  = NIRQ'(rand_bits(NIRQ)) | NIRQ'(1);
    pend_m = irq_i;
    wait_intr(1'b1);
    irq_i  = irq_i | NIRQ'(rand_bits(NIRQ));   // More edges while others pend
    pend_m = irq_i;

    // One acknowledge per pending line with the lowest first
    while (pend_m != '0) begin
      @(negedge clk);
      inta_i = 1'b1;
      #1;
      check("bus_o.dat", bus_o.dat, `SOC_INT_VEC_BASE + 16'(lowest_pending(pend_m)));
      @(negedge clk);
      nmia_i = 1'b1;   // NMI vector wins over inta
      #1;
      check("bus_o.dat", bus_o.dat, `SOC_NMI_VEC);
      @(negedge clk);
      inta_i = 1'b0;
      nmia_i = 1'b0;
      pend_m[lowest_pending(pend_m)] = 1'b0;
      @(negedge clk);
      check("intr_o", intr_o, |pend_m);
    end
    irq_i = '0;

    @(negedge clk);
    if (exp_q.size() != 0)
      abort_run("Some acked reads were never compared");
    else
      $display("Test passed");
    $finish;
  end

endmodule

// File: rom.hex
// Boot ROM words 0 to 15, one 16-bit hex value per line
ea5b
e000
f000
31c0
8ed8
8ec0
bc00
7c00
b800
f100
e5ff
cd19
fa90
f4eb
fe00
55aa

// File: list.f
+incdir+rtl
+incdir+test
rtl/soc_pkg.sv
rtl/reset_debounce.sv
rtl/bus_decoder.sv
rtl/boot_rom.sv
rtl/base_ram.sv
rtl/gpio_port.sv
rtl/int_ctrl.sv
rtl/soc_top.sv
test/tb_soc.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_soc > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_soc > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
